// File: hdl/tia_hm_defs.svh
`ifndef TIA_HM_DEFS_SVH
`define TIA_HM_DEFS_SVH

// bus
`define HM_ADDR_W 6
`define HM_DATA_W 8

// object positions
`define HM_POS_W 8
`define HM_LINE_PIXELS 160  // visible pixels per line
`define HM_NUM_OBJ 5        // p0 p1 m0 m1 bl

// hmove sequencing
`define HM_STEP_CLKS 4      // clocks per ripple step
`define HM_NUM_STEPS 16

`endif

// File: hdl/tia_hm_pkg.sv
`include "tia_hm_defs.svh"

package tia_hm_pkg;

  // chip register addresses
  typedef enum logic [`HM_ADDR_W-1:0] {
    resp0 = 6'h10,
    resp1 = 6'h11,
    resm0 = 6'h12,
    resm1 = 6'h13,
    resbl = 6'h14,
    hmp0  = 6'h20,
    hmp1  = 6'h21,
    hmm0  = 6'h22,
    hmm1  = 6'h23,
    hmbl  = 6'h24,
    hmove = 6'h2A,
    hmclr = 6'h2B
  } tia_reg_e;

  typedef enum logic [2:0] {
    obj_p0,
    obj_p1,
    obj_m0,
    obj_m1,
    obj_bl
  } obj_e;

  typedef enum logic [1:0] {st_idle, st_wait, st_ack} bus_state_e;

endpackage

// File: hdl/hm_bus_decode.sv
`timescale 1ns/1ps
`include "tia_hm_defs.svh"

module hm_bus_decode
  import tia_hm_pkg::*;
(
  input  logic                  hphi,
  input  logic                  rst_n,
  input  logic                  req,
  input  logic [`HM_ADDR_W-1:0] addr,
  input  logic [`HM_DATA_W-1:0] data,
  input  logic                  busy,
  output logic                  ack,
  output logic                  hm_wr,
  output obj_e                  hm_obj,
  output logic [3:0]            hm_val,
  output logic                  clr,
  output logic                  move_start,
  output logic                  res_wr,
  output obj_e                  res_obj,
  output logic [`HM_POS_W-1:0]  res_pos
);

  bus_state_e state;
  tia_reg_e   reg_sel;
  obj_e       obj_sel;
  logic       accept;

  assign reg_sel = tia_reg_e'(addr);
  assign accept  = (state == st_wait) && !busy;  // held off during hmove

  always_comb begin
    case (reg_sel)
      resp0, hmp0: obj_sel = obj_p0;
      resp1, hmp1: obj_sel = obj_p1;
      resm0, hmm0: obj_sel = obj_m0;
      resm1, hmm1: obj_sel = obj_m1;
      resbl, hmbl: obj_sel = obj_bl;
      default:     obj_sel = obj_p0;
    endcase
  end

  always_ff @(posedge hphi) begin
    if (!rst_n) begin
      state      <= st_idle;
      ack        <= 1'b0;
      hm_wr      <= 1'b0;
      clr        <= 1'b0;
      move_start <= 1'b0;
      res_wr     <= 1'b0;
    end else begin
      hm_wr      <= 1'b0;  // strobes last one cycle
      clr        <= 1'b0;
      move_start <= 1'b0;
      res_wr     <= 1'b0;
      case (state)
        st_idle: if (req) state <= st_wait;
        st_wait: if (accept) begin
          ack   <= 1'b1;
          state <= st_ack;
          case (reg_sel)
            resp0, resp1, resm0, resm1, resbl: res_wr <= 1'b1;
            hmp0, hmp1, hmm0, hmm1, hmbl:      hm_wr  <= 1'b1;
            hmove:   move_start <= 1'b1;
            hmclr:   clr        <= 1'b1;
            default: ;  // unknown address, ack only
          endcase
        end
        st_ack: if (!req) begin
          ack   <= 1'b0;
          state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // payload captured alongside the strobes
  always_ff @(posedge hphi) begin
    if (accept) begin
      hm_obj  <= obj_sel;
      res_obj <= obj_sel;
      hm_val  <= data[`HM_DATA_W-1 -: 4];  // d7..d4
      res_pos <= data[`HM_POS_W-1:0];
    end
  end

endmodule

// File: hdl/motion_registers.sv
`timescale 1ns/1ps
`include "tia_hm_defs.svh"

module motion_registers
  import tia_hm_pkg::*;
(
  input  logic                   hphi,
  input  logic                   rst_n,
  input  logic                   hm_wr,
  input  obj_e                   hm_obj,
  input  logic [3:0]             hm_val,
  input  logic                   clr,
  input  logic                   move_start,
  output logic                   busy,
  output logic [`HM_NUM_OBJ-1:0] pulse
);

  localparam int CNT_W  = $clog2(`HM_STEP_CLKS);
  localparam int STEP_W = $clog2(`HM_NUM_STEPS);

  localparam logic [CNT_W-1:0]  LAST_CLK  = CNT_W'(`HM_STEP_CLKS - 1);
  localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`HM_NUM_STEPS - 1);

  logic [3:0]        motion [`HM_NUM_OBJ];  // signed nibbles, two's complement
  logic [CNT_W-1:0]  clk_cnt;
  logic [STEP_W-1:0] step;                  // ripple counter
  logic              step_now;

  assign step_now = busy && (clk_cnt == LAST_CLK);

  // motion value storage
  always_ff @(posedge hphi) begin
    if (!rst_n) begin
      for (int i = 0; i < `HM_NUM_OBJ; i++) begin
        motion[i] <= 4'd0;
      end
    end else if (clr) begin
      for (int i = 0; i < `HM_NUM_OBJ; i++) begin
        motion[i] <= 4'd0;
      end
    end else if (hm_wr) begin
      motion[int'(hm_obj)] <= hm_val;
    end
  end

  // clock-divided step counter, 64 busy cycles in all
  always_ff @(posedge hphi) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      step    <= '0;
    end else if (move_start) begin
      busy    <= 1'b1;
      clk_cnt <= '0;
      step    <= '0;
    end else if (busy) begin
      clk_cnt <= clk_cnt + 1'b1;
      if (step_now) begin
        step <= step + 1'b1;
        if (step == LAST_STEP) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // comparison stays open while step < value ^ 8
  always_comb begin
    for (int i = 0; i < `HM_NUM_OBJ; i++) begin
      pulse[i] = step_now && (step < (motion[i] ^ 4'b1000));
    end
  end

endmodule

// File: hdl/object_position_counters.sv
`timescale 1ns/1ps
`include "tia_hm_defs.svh"

module object_position_counters
  import tia_hm_pkg::*;
(
  input  logic                   hphi,
  input  logic                   rst_n,
  input  logic                   res_wr,
  input  obj_e                   res_obj,
  input  logic [`HM_POS_W-1:0]   res_pos,
  input  logic                   move_start,
  input  logic [`HM_NUM_OBJ-1:0] pulse,
  output logic [`HM_POS_W-1:0]   p0_pos,
  output logic [`HM_POS_W-1:0]   p1_pos,
  output logic [`HM_POS_W-1:0]   m0_pos,
  output logic [`HM_POS_W-1:0]   m1_pos,
  output logic [`HM_POS_W-1:0]   bl_pos
);

  localparam logic [`HM_POS_W-1:0] LINE = `HM_LINE_PIXELS;

  logic [`HM_POS_W-1:0] pos [`HM_NUM_OBJ];

  // single subtract is enough for 0..255
  function automatic logic [`HM_POS_W-1:0] wrap_line(input logic [`HM_POS_W-1:0] v);
    return (v >= LINE) ? v - LINE : v;
  endfunction

  always_ff @(posedge hphi) begin
    if (!rst_n) begin
      for (int i = 0; i < `HM_NUM_OBJ; i++) begin
        pos[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `HM_NUM_OBJ; i++) begin
        if (res_wr && (int'(res_obj) == i)) begin
          pos[i] <= wrap_line(res_pos);
        end else if (move_start) begin
          pos[i] <= wrap_line(pos[i] + `HM_POS_W'(8));  // clocks lost in blank
        end else if (pulse[i]) begin
          pos[i] <= (pos[i] == '0) ? LINE - 1'b1 : pos[i] - 1'b1;  // one pixel left
        end
      end
    end
  end

  assign p0_pos = pos[int'(obj_p0)];
  assign p1_pos = pos[int'(obj_p1)];
  assign m0_pos = pos[int'(obj_m0)];
  assign m1_pos = pos[int'(obj_m1)];
  assign bl_pos = pos[int'(obj_bl)];

endmodule

// File: hdl/tia_hm_top.sv
`timescale 1ns/1ps
`include "tia_hm_defs.svh"

module tia_hm_top
  import tia_hm_pkg::*;
(
  input  logic                  hphi,
  input  logic                  rst_n,
  input  logic                  req,
  input  logic [`HM_ADDR_W-1:0] addr,
  input  logic [`HM_DATA_W-1:0] data,
  output logic                  ack,
  output logic                  busy,
  output logic [`HM_POS_W-1:0]  p0_pos,
  output logic [`HM_POS_W-1:0]  p1_pos,
  output logic [`HM_POS_W-1:0]  m0_pos,
  output logic [`HM_POS_W-1:0]  m1_pos,
  output logic [`HM_POS_W-1:0]  bl_pos
);

  logic                   hm_wr;
  obj_e                   hm_obj;
  logic [3:0]             hm_val;
  logic                   clr;
  logic                   move_start;  // also feeds the +8 in the counters
  logic                   res_wr;
  obj_e                   res_obj;
  logic [`HM_POS_W-1:0]   res_pos;
  logic [`HM_NUM_OBJ-1:0] pulse;

  hm_bus_decode i_decode (
    .hphi(hphi), .rst_n(rst_n), .req(req), .addr(addr), .data(data), .busy(busy),
    .ack(ack), .hm_wr(hm_wr), .hm_obj(hm_obj), .hm_val(hm_val), .clr(clr),
    .move_start(move_start), .res_wr(res_wr), .res_obj(res_obj), .res_pos(res_pos)
  );

  motion_registers i_motion (
    .hphi(hphi), .rst_n(rst_n), .hm_wr(hm_wr), .hm_obj(hm_obj), .hm_val(hm_val),
    .clr(clr), .move_start(move_start), .busy(busy), .pulse(pulse)
  );

  object_position_counters i_pos (
    .hphi(hphi), .rst_n(rst_n), .res_wr(res_wr), .res_obj(res_obj),
    .res_pos(res_pos), .move_start(move_start), .pulse(pulse),
    .p0_pos(p0_pos), .p1_pos(p1_pos), .m0_pos(m0_pos), .m1_pos(m1_pos),
    .bl_pos(bl_pos)
  );

endmodule

// File: verification/tia_hm_props.sv
`timescale 1ns/1ps
`include "tia_hm_defs.svh"

module tia_hm_props (
  input logic hphi,
  input logic rst_n,
  input logic req,
  input logic ack,
  input logic busy
);

  localparam int BUSY_CLKS = `HM_STEP_CLKS * `HM_NUM_STEPS;

  a_ack_needs_req: assert property (@(posedge hphi) disable iff (!rst_n)
    $rose(ack) |-> $past(req))
    else $error("ack rose with no pending req");

  // four-phase: ack holds until the host lets go of req
  a_ack_held: assert property (@(posedge hphi) disable iff (!rst_n)
    (ack && req) |=> ack)
    else $error("ack dropped while req was still high");

  a_busy_len: assert property (@(posedge hphi) disable iff (!rst_n)
    $rose(busy) |-> ##BUSY_CLKS $fell(busy))
    else $error("busy did not last one full hmove sequence");

endmodule

bind hm_bus_decode tia_hm_props i_props (
  .hphi(hphi), .rst_n(rst_n), .req(req), .ack(ack), .busy(busy)
);

// File: verification/tia_hm_checker.sv
`timescale 1ns/1ps
`include "tia_hm_defs.svh"

module tia_hm_checker
  import tia_hm_pkg::*;
(
  input  logic                  hphi,
  input  logic                  rst_n,
  input  logic                  req,
  input  logic [`HM_ADDR_W-1:0] addr,
  input  logic [`HM_DATA_W-1:0] data,
  input  logic                  ack,
  input  logic                  busy,
  input  logic [`HM_POS_W-1:0]  p0_pos,
  input  logic [`HM_POS_W-1:0]  p1_pos,
  input  logic [`HM_POS_W-1:0]  m0_pos,
  input  logic [`HM_POS_W-1:0]  m1_pos,
  input  logic [`HM_POS_W-1:0]  bl_pos,
  input  logic                  check_stb,
  input  int                    check_id,
  output int                    tests_run,
  output int                    tests_failed
);

  int         exp_pos [`HM_NUM_OBJ];
  logic [3:0] exp_mot [`HM_NUM_OBJ];
  logic       ack_q;
  logic       req_q;
  int         pending_errs;

  // new position is old minus signed nibble mod line length
  function automatic int pos_after_hmove(input int old_pos, input logic [3:0] nib);
    int shift;
    int r;
    shift = (nib >= 4'd8) ? int'(nib) - 16 : int'(nib);
    r = old_pos - shift;
    if (r < 0) r = r + `HM_LINE_PIXELS;
    else if (r >= `HM_LINE_PIXELS) r = r - `HM_LINE_PIXELS;
    return r;
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1: return "reset state";
      2: return "position loads";
      3: return "motion edge values";
      4: return "random motion";
      5: return "hmclr then hmove";
      6: return "write during busy";
      7: return "unknown address";
      default: return "unnamed";
    endcase
  endfunction

  task automatic apply_write(input logic [`HM_ADDR_W-1:0] a, input logic [`HM_DATA_W-1:0] d);
    case (a)
      resp0, resp1, resm0, resm1, resbl:
        exp_pos[int'(a) - int'(resp0)] = int'(d) % `HM_LINE_PIXELS;
      hmp0, hmp1, hmm0, hmm1, hmbl:
        exp_mot[int'(a) - int'(hmp0)] = d[7:4];  // d7..d4
      hmclr: for (int k = 0; k < `HM_NUM_OBJ; k++) exp_mot[k] = 4'd0;
      hmove: for (int k = 0; k < `HM_NUM_OBJ; k++) begin
        exp_pos[k] = pos_after_hmove(exp_pos[k], exp_mot[k]);
      end
      default: ;  // no effect
    endcase
  endtask

  task automatic compare_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v, inout int errs);
    if (exp_v !== act_v) begin
      $display("ERROR %0t ns: %s expected %0d, got %0d", $time, name, exp_v, act_v);
      errs++;
    end
  endtask

  task automatic compare_all(input int id);
    int          errs;
    logic [31:0] act [`HM_NUM_OBJ];
    string       names [`HM_NUM_OBJ];
    errs  = pending_errs;
    act   = '{32'(p0_pos), 32'(p1_pos), 32'(m0_pos), 32'(m1_pos), 32'(bl_pos)};
    names = '{"p0_pos", "p1_pos", "m0_pos", "m1_pos", "bl_pos"};
    for (int k = 0; k < `HM_NUM_OBJ; k++) begin
      compare_value(names[k], exp_pos[k], act[k], errs);
    end
    compare_value("ack", 32'd0, 32'(ack), errs);  // bus idle between tests
    compare_value("busy", 32'd0, 32'(busy), errs);
    tests_run++;
    if (errs == 0) begin
      $display("test %0d %s: ok", id, test_name(id));
    end else begin
      tests_failed++;
      $display("test %0d %s: FAILED with %0d errors", id, test_name(id), errs);
    end
    pending_errs = 0;
  endtask

  initial begin
    tests_run    = 0;
    tests_failed = 0;
    pending_errs = 0;
  end

  // inputs settle at the falling edge and are sampled here on the rising edge
  always @(posedge hphi) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
      req_q <= 1'b0;
      for (int k = 0; k < `HM_NUM_OBJ; k++) begin
        exp_pos[k] = 0;
        exp_mot[k] = 4'd0;
      end
    end else begin
      ack_q <= ack;
      req_q <= req;
      if (ack && !ack_q && busy) begin
        $display("ack was granted at %0t ns while an hmove was still running", $time);
        pending_errs++;
      end
      if (ack && !ack_q && req_q) apply_write(addr, data);
      if (check_stb) compare_all(check_id);
    end
  end

endmodule

// File: verification/tb_tia_hm.sv
`timescale 1ns/1ps
`include "tia_hm_defs.svh"

module tb_tia_hm
  import tia_hm_pkg::*;
();

  localparam int ACK_TIMEOUT  = 200;  // covers a full 64-cycle hold-off
  localparam int BUSY_TIMEOUT = 200;

  logic                  hphi;
  logic                  rst_n;
  logic                  req;
  logic [`HM_ADDR_W-1:0] addr;
  logic [`HM_DATA_W-1:0] data;
  logic                  ack;
  logic                  busy;
  logic [`HM_POS_W-1:0]  p0_pos, p1_pos, m0_pos, m1_pos, bl_pos;
  logic                  check_stb;
  int                    check_id;
  int                    tests_run;
  int                    tests_failed;
  int                    seed;

  initial hphi = 1'b0;
  always #50 hphi = ~hphi;

  tia_hm_top i_dut (
    .hphi(hphi), .rst_n(rst_n), .req(req), .addr(addr), .data(data), .ack(ack),
    .busy(busy), .p0_pos(p0_pos), .p1_pos(p1_pos), .m0_pos(m0_pos),
    .m1_pos(m1_pos), .bl_pos(bl_pos)
  );

  tia_hm_checker i_chk (
    .hphi(hphi), .rst_n(rst_n), .req(req), .addr(addr), .data(data), .ack(ack),
    .busy(busy), .p0_pos(p0_pos), .p1_pos(p1_pos), .m0_pos(m0_pos),
    .m1_pos(m1_pos), .bl_pos(bl_pos), .check_stb(check_stb), .check_id(check_id),
    .tests_run(tests_run), .tests_failed(tests_failed)
  );

  task automatic fail_run(input string what);
    $display("%s (at %0t ns)", what, $time);
    $display("=== FAIL ===");
    $finish;
  endtask

  task automatic wait_ack(input logic level, input string what);
    int n;
    n = 0;
    while (ack !== level) begin
      @(negedge hphi);
      n++;
      if (n > ACK_TIMEOUT) fail_run(what);
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy !== 1'b0) begin
      @(negedge hphi);
      n++;
      if (n > BUSY_TIMEOUT) fail_run("busy never fell after hmove");
    end
  endtask

  task automatic bus_write(input logic [`HM_ADDR_W-1:0] a, input logic [`HM_DATA_W-1:0] d);
    @(negedge hphi);
    addr = a;
    data = d;
    req  = 1'b1;
    wait_ack(1'b1, "write was never acknowledged");
    req = 1'b0;
    wait_ack(1'b0, "ack stayed high after req dropped");
  endtask

  task automatic run_hmove();
    bus_write(hmove, 8'h00);
    wait_idle();
  endtask

  task automatic check_positions(input int id);
    @(negedge hphi);
    check_id  = id;
    check_stb = 1'b1;
    @(negedge hphi);
    check_stb = 1'b0;
  endtask

  initial begin
    logic [3:0] nib;
    seed      = 65;
    rst_n     = 1'b0;
    req       = 1'b0;
    addr      = '0;
    data      = '0;
    check_stb = 1'b0;
    check_id  = 0;
    repeat (8) @(negedge hphi);
    rst_n = 1'b1;
    check_positions(1);

    bus_write(resp0, 8'd17);
    bus_write(resp1, 8'd159);
    bus_write(resm0, 8'd0);
    bus_write(resm1, 8'd200);  // wraps to 40
    bus_write(resbl, 8'd80);
    check_positions(2);

    // +7 from 0 and -8 from 159 both wrap
    bus_write(resp0, 8'd0);
    bus_write(resp1, 8'd159);
    bus_write(resm0, 8'd1);
    bus_write(resm1, 8'd158);
    bus_write(hmp0, 8'h70);
    bus_write(hmp1, 8'h80);
    bus_write(hmm0, 8'h30);
    bus_write(hmm1, 8'hB0);
    bus_write(hmbl, 8'($random(seed)));
    run_hmove();
    check_positions(3);

    for (int r = 0; r < 4; r++) begin
      for (int j = 0; j < `HM_NUM_OBJ; j++) begin
        bus_write(`HM_ADDR_W'(int'(resp0) + j), 8'($random(seed)));
        nib = 4'($random(seed));
        bus_write(`HM_ADDR_W'(int'(hmp0) + j), {nib, 4'h0});
      end
      run_hmove();
      check_positions(4);
    end

    bus_write(hmclr, 8'h00);
    run_hmove();
    check_positions(5);

    bus_write(hmp0, 8'h30);
    bus_write(hmove, 8'h00);
    if (busy !== 1'b1) fail_run("hmove write did not raise busy");
    bus_write(hmbl, 8'hB0);  // held off until busy falls
    wait_idle();
    check_positions(6);
    run_hmove();
    check_positions(6);

    bus_write(6'h3F, 8'hFF);
    bus_write(6'h15, 8'h42);
    run_hmove();  // motion values stay untouched too
    check_positions(7);

    $display("tests run %0d, passed %0d, failed %0d", tests_run,
             tests_run - tests_failed, tests_failed);
    if (tests_failed == 0 && tests_run > 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+hdl
hdl/tia_hm_pkg.sv
hdl/hm_bus_decode.sv
hdl/motion_registers.sv
hdl/object_position_counters.sv
hdl/tia_hm_top.sv
verification/tia_hm_props.sv
verification/tia_hm_checker.sv
verification/tb_tia_hm.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator, result taken from sim.log

LOG=sim.log

verilator --binary --timing --assert -sv -Wno-fatal -f sim.f \
  --top-module tb_tia_hm -Mdir obj_dir -o tb_tia_hm
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_tia_hm > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failures"
exit 0
